// ==== Makefile ====
TOP = tb_idu_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

// ==== include/idu_defines.svh ====
`ifndef IDU_DEFINES_SVH
`define IDU_DEFINES_SVH

// instruction word.
`define ISA_WIDTH 32

// field widths of the base formats.
`define FUNCT7_WIDTH 7
`define FUNCT3_WIDTH 3
`define OPCODE_WIDTH 7
`define REG_IDX_WIDTH 5

// decoded instruction number.
`define INST_NUM_WIDTH 6

// the one system word that is decoded.
`define EBREAK_WORD `ISA_WIDTH'b0000000_00001_00000_000_00000_1110011

`endif

// ==== rtl/idu_ctrl.sv ====
`include "idu_defines.svh"

module idu_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  rv_isa_pkg::rv_inst_u  inst,
    input  idu_pkg::inst_class_e  cls,
    input  logic [`ISA_WIDTH-1:0] imm,
    input  idu_pkg::inst_num_e    load_num,
    input  idu_pkg::inst_num_e    store_num,
    input  idu_pkg::inst_num_e    branch_num,
    input  idu_pkg::inst_num_e    op_imm_num,
    input  idu_pkg::inst_num_e    op_num,
    input  idu_pkg::inst_num_e    jalr_num,
    input  idu_pkg::inst_num_e    srli_addi_num,
    input  idu_pkg::inst_num_e    add_add_num,
    input  idu_pkg::inst_num_e    srl_add_num,
    input  idu_pkg::inst_num_e    ebreak_num,
    output logic                  out_valid,
    input  logic                  out_ready,
    output idu_pkg::idu_out_t     out
);

    import idu_pkg::*;

    inst_num_e num;
    idu_out_t  rec;
    logic      has_rs2;
    logic      has_rd;

    always_comb begin
        case (cls)
            cls_load:   num = load_num;
            cls_store:  num = store_num;
            cls_branch: num = branch_num;
            cls_jal:    num = num_jal;
            cls_jalr:   num = jalr_num;
            cls_lui:    num = num_lui;
            cls_auipc:  num = num_auipc;
            cls_op_imm: num = (op_imm_num == num_srli) ? srli_addi_num : op_imm_num;
            cls_op: begin
                if (op_num == num_add) begin
                    num = add_add_num;
                end else if (op_num == num_srl) begin
                    num = srl_add_num;
                end else begin
                    num = op_num;
                end
            end
            cls_system: num = ebreak_num;
            default:    num = num_inv;
        endcase
    end

    // register fields that the format actually carries.
    assign has_rs2 = (cls == cls_store) || (cls == cls_branch) || (cls == cls_op);
    assign has_rd  = (cls == cls_load) || (cls == cls_jalr) || (cls == cls_op_imm) ||
                     (cls == cls_op) || (cls == cls_lui) || (cls == cls_auipc) ||
                     (cls == cls_jal);

    always_comb begin
        rec.inst_num = num;
        rec.rd       = has_rd ? inst.r.rd : '0;
        rec.rs1      = inst.r.rs1;
        rec.rs2      = has_rs2 ? inst.r.rs2 : '0;
        rec.imm      = imm;
        rec.rd_we    = (num != num_inv) && (num != num_ebreak) &&
                       (cls != cls_store) && (cls != cls_branch);
    end

    assign in_ready = !out_valid || out_ready; // empty or draining.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= rec;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out));

    a_no_drop: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid);

endmodule

// ==== rtl/idu_funct3.sv ====
`include "idu_defines.svh"

module idu_funct3 (
    input  rv_isa_pkg::rv_inst_u inst,
    output idu_pkg::inst_num_e   load_num,
    output idu_pkg::inst_num_e   store_num,
    output idu_pkg::inst_num_e   branch_num,
    output idu_pkg::inst_num_e   op_imm_num,
    output idu_pkg::inst_num_e   op_num,
    output idu_pkg::inst_num_e   jalr_num
);

    import idu_pkg::*;

    logic f7_zero;

    assign f7_zero = (inst.r.funct7 == `FUNCT7_WIDTH'b0);

    always_comb begin
        load_num   = num_inv;
        store_num  = num_inv;
        branch_num = num_inv;
        op_imm_num = num_inv;
        op_num     = num_inv;
        jalr_num   = (inst.i.funct3 == `FUNCT3_WIDTH'd0) ? num_jalr : num_inv;

        case (inst.i.funct3)
            3'd0: load_num = num_lb;
            3'd1: load_num = num_lh;
            3'd2: load_num = num_lw;
            3'd4: load_num = num_lbu;
            3'd5: load_num = num_lhu;
            default: load_num = num_inv;
        endcase

        case (inst.s.funct3)
            3'd0: store_num = num_sb;
            3'd1: store_num = num_sh;
            3'd2: store_num = num_sw;
            default: store_num = num_inv;
        endcase

        case (inst.b.funct3)
            3'd0: branch_num = num_beq;
            3'd1: branch_num = num_bne;
            3'd4: branch_num = num_blt;
            3'd5: branch_num = num_bge;
            3'd6: branch_num = num_bltu;
            3'd7: branch_num = num_bgeu;
            default: branch_num = num_inv;
        endcase

        case (inst.i.funct3)
            3'd0: op_imm_num = num_addi;
            3'd1: op_imm_num = f7_zero ? num_slli : num_inv;
            3'd2: op_imm_num = num_slti;
            3'd3: op_imm_num = num_sltiu;
            3'd4: op_imm_num = num_xori;
            3'd5: op_imm_num = num_srli; // slot key, funct7 settles it.
            3'd6: op_imm_num = num_ori;
            default: op_imm_num = num_andi;
        endcase

        case (inst.r.funct3)
            3'd0: op_num = num_add; // slot key.
            3'd1: op_num = f7_zero ? num_sll : num_inv;
            3'd2: op_num = f7_zero ? num_slt : num_inv;
            3'd3: op_num = f7_zero ? num_sltu : num_inv;
            3'd4: op_num = f7_zero ? num_xor : num_inv;
            3'd5: op_num = num_srl; // slot key.
            3'd6: op_num = f7_zero ? num_or : num_inv;
            default: op_num = f7_zero ? num_and : num_inv;
        endcase
    end

endmodule

// ==== rtl/idu_funct7.sv ====
`include "idu_defines.svh"

module idu_funct7 (
    input  rv_isa_pkg::rv_inst_u inst,
    output idu_pkg::inst_num_e   srli_addi_num,
    output idu_pkg::inst_num_e   add_add_num,
    output idu_pkg::inst_num_e   srl_add_num,
    output idu_pkg::inst_num_e   ebreak_num
);

    import idu_pkg::*;

    always_comb begin
        case (inst.r.funct7)
            `FUNCT7_WIDTH'b0000000: begin
                srli_addi_num = num_srli;
                add_add_num   = num_add;
                srl_add_num   = num_srl;
            end
            `FUNCT7_WIDTH'b0100000: begin
                srli_addi_num = num_srai;
                add_add_num   = num_sub;
                srl_add_num   = num_sra;
            end
            default: begin
                srli_addi_num = num_inv;
                add_add_num   = num_inv;
                srl_add_num   = num_inv;
            end
        endcase
    end

    // whole word must match, no don't-care bits.
    assign ebreak_num = (inst == `EBREAK_WORD) ? num_ebreak : num_inv;

endmodule

// ==== rtl/idu_imm_gen.sv ====
`include "idu_defines.svh"

module idu_imm_gen (
    input  rv_isa_pkg::rv_inst_u  inst,
    input  idu_pkg::inst_class_e  cls,
    output logic [`ISA_WIDTH-1:0] imm
);

    import idu_pkg::*;

    always_comb begin
        case (cls)
            cls_load, cls_jalr, cls_op_imm, cls_system: begin
                imm = {{(`ISA_WIDTH-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            end
            cls_store: begin
                imm = {{(`ISA_WIDTH-12){inst.s.imm_11_5[6]}},
                       inst.s.imm_11_5, inst.s.imm_4_0};
            end
            cls_branch: begin
                imm = {{(`ISA_WIDTH-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            cls_lui, cls_auipc: begin
                imm = {inst.u.imm_31_12, 12'b0}; // upper 20 bits, no extension.
            end
            cls_jal: begin
                imm = {{(`ISA_WIDTH-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            default: begin
                imm = '0; // register alu and undecoded words.
            end
        endcase
    end

endmodule

// ==== rtl/idu_opcode.sv ====
module idu_opcode (
    input  rv_isa_pkg::rv_opcode_e opcode,
    output idu_pkg::inst_class_e   cls
);

    import rv_isa_pkg::*;
    import idu_pkg::*;

    always_comb begin
        cls = cls_none;
        if (opcode[1:0] == 2'b11) begin // compressed space never decodes.
            case (opcode)
                opc_load:   cls = cls_load;
                opc_store:  cls = cls_store;
                opc_branch: cls = cls_branch;
                opc_jal:    cls = cls_jal;
                opc_jalr:   cls = cls_jalr;
                opc_lui:    cls = cls_lui;
                opc_auipc:  cls = cls_auipc;
                opc_op_imm: cls = cls_op_imm;
                opc_op:     cls = cls_op;
                opc_system: cls = cls_system;
                default:    cls = cls_none;
            endcase
        end
    end

endmodule

// ==== rtl/idu_pkg.sv ====
`include "idu_defines.svh"

package idu_pkg;

    // inv must stay zero.
    typedef enum logic [`INST_NUM_WIDTH-1:0] {
        num_inv = 0,
        num_lui, num_auipc, num_jal, num_jalr,
        num_beq, num_bne, num_blt, num_bge, num_bltu, num_bgeu,
        num_lb, num_lh, num_lw, num_lbu, num_lhu,
        num_sb, num_sh, num_sw,
        num_addi, num_slti, num_sltiu, num_xori, num_ori, num_andi,
        num_slli, num_srli, num_srai,
        num_add, num_sub, num_sll, num_slt, num_sltu,
        num_xor, num_srl, num_sra, num_or, num_and,
        num_ebreak
    } inst_num_e;

    typedef enum logic [3:0] {
        cls_none,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_lui,
        cls_auipc,
        cls_op_imm,
        cls_op,
        cls_system
    } inst_class_e;

    typedef struct packed {
        inst_num_e                inst_num;
        logic [`REG_IDX_WIDTH-1:0] rd;
        logic [`REG_IDX_WIDTH-1:0] rs1;
        logic [`REG_IDX_WIDTH-1:0] rs2;
        logic [`ISA_WIDTH-1:0]     imm;
        logic                      rd_we;
    } idu_out_t;

endpackage

// ==== rtl/idu_top.sv ====
`include "idu_defines.svh"

module idu_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  rv_isa_pkg::rv_inst_u inst,
    output logic                 out_valid,
    input  logic                 out_ready,
    output idu_pkg::idu_out_t    out
);

    import idu_pkg::*;

    inst_class_e           cls;
    logic [`ISA_WIDTH-1:0] imm;
    inst_num_e             load_num;
    inst_num_e             store_num;
    inst_num_e             branch_num;
    inst_num_e             op_imm_num;
    inst_num_e             op_num;
    inst_num_e             jalr_num;
    inst_num_e             srli_addi_num;
    inst_num_e             add_add_num;
    inst_num_e             srl_add_num;
    inst_num_e             ebreak_num;

    idu_opcode u_opcode (
        .opcode(inst.r.opcode),
        .cls   (cls)
    );

    idu_funct3 u_funct3 (
        .inst      (inst),
        .load_num  (load_num),
        .store_num (store_num),
        .branch_num(branch_num),
        .op_imm_num(op_imm_num),
        .op_num    (op_num),
        .jalr_num  (jalr_num)
    );

    idu_funct7 u_funct7 (
        .inst         (inst),
        .srli_addi_num(srli_addi_num),
        .add_add_num  (add_add_num),
        .srl_add_num  (srl_add_num),
        .ebreak_num   (ebreak_num)
    );

    idu_imm_gen u_imm_gen (
        .inst(inst),
        .cls (cls),
        .imm (imm)
    );

    idu_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .inst         (inst),
        .cls          (cls),
        .imm          (imm),
        .load_num     (load_num),
        .store_num    (store_num),
        .branch_num   (branch_num),
        .op_imm_num   (op_imm_num),
        .op_num       (op_num),
        .jalr_num     (jalr_num),
        .srli_addi_num(srli_addi_num),
        .add_add_num  (add_add_num),
        .srl_add_num  (srl_add_num),
        .ebreak_num   (ebreak_num),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out          (out)
    );

endmodule

// ==== rtl/rv_isa_pkg.sv ====
`include "idu_defines.svh"

package rv_isa_pkg;

    typedef logic [`FUNCT7_WIDTH-1:0] funct7_t;
    typedef logic [`FUNCT3_WIDTH-1:0] funct3_t;
    typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

    // major opcodes, low two bits are always 11.
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } rv_opcode_e;

    typedef struct packed {
        funct7_t    funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_t    funct3;
        reg_idx_t   rd;
        rv_opcode_e opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        funct3_t     funct3;
        reg_idx_t    rd;
        rv_opcode_e  opcode;
    } rv_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_t    funct3;
        logic [4:0] imm_4_0;
        rv_opcode_e opcode;
    } rv_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_t    funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        rv_opcode_e opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        rv_opcode_e  opcode;
    } rv_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        rv_opcode_e opcode;
    } rv_j_t;

    // one word, six views.
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_inst_u;

endpackage

// ==== verification/tb_idu_top.sv ====
module tb_idu_top;

    import rv_isa_pkg::*;
    import idu_pkg::*;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      in_valid;
    logic      in_ready;
    rv_inst_u  inst;
    logic      out_valid;
    logic      out_ready;
    idu_out_t  out;

    logic [31:0] lcg_state;
    idu_out_t    exp_q[$];
    idu_out_t    exp_head;
    idu_out_t    last_exp;
    int          pending;
    int          sent;
    int          mismatch_cnt;
    int          fail_cnt;
    logic        timed_out;
    logic        random_ready;
    bit          seen [0:63];

    idu_top uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .inst     (inst),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out      (out)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected record, straight from the RV32I encoding rules.
    function automatic idu_out_t ref_decode(input logic [31:0] w);
        idu_out_t    d;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        f7z;
        logic        f7a;
        logic [31:0] i_imm;
        opc   = w[6:0];
        f3    = w[14:12];
        f7z   = (w[31:25] == 7'h00);
        f7a   = (w[31:25] == 7'h20);
        i_imm = {{20{w[31]}}, w[31:20]};
        d     = '0;
        d.rs1 = w[19:15]; // rs1 is passed for every format.
        case (opc)
            7'b0000011: begin
                d.rd  = w[11:7];
                d.imm = i_imm;
                case (f3)
                    3'd0: d.inst_num = num_lb;
                    3'd1: d.inst_num = num_lh;
                    3'd2: d.inst_num = num_lw;
                    3'd4: d.inst_num = num_lbu;
                    3'd5: d.inst_num = num_lhu;
                    default: d.inst_num = num_inv;
                endcase
            end
            7'b0100011: begin
                d.rs2 = w[24:20];
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                case (f3)
                    3'd0: d.inst_num = num_sb;
                    3'd1: d.inst_num = num_sh;
                    3'd2: d.inst_num = num_sw;
                    default: d.inst_num = num_inv;
                endcase
            end
            7'b1100011: begin
                d.rs2 = w[24:20];
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'd0: d.inst_num = num_beq;
                    3'd1: d.inst_num = num_bne;
                    3'd4: d.inst_num = num_blt;
                    3'd5: d.inst_num = num_bge;
                    3'd6: d.inst_num = num_bltu;
                    3'd7: d.inst_num = num_bgeu;
                    default: d.inst_num = num_inv;
                endcase
            end
            7'b1101111: begin
                d.rd       = w[11:7];
                d.imm      = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                d.inst_num = num_jal;
            end
            7'b1100111: begin
                d.rd       = w[11:7];
                d.imm      = i_imm;
                d.inst_num = (f3 == 3'd0) ? num_jalr : num_inv;
            end
            7'b0110111, 7'b0010111: begin
                d.rd       = w[11:7];
                d.imm      = {w[31:12], 12'b0};
                d.inst_num = (opc == 7'b0110111) ? num_lui : num_auipc;
            end
            7'b0010011: begin
                d.rd  = w[11:7];
                d.imm = i_imm;
                case (f3)
                    3'd0: d.inst_num = num_addi;
                    3'd1: d.inst_num = f7z ? num_slli : num_inv;
                    3'd2: d.inst_num = num_slti;
                    3'd3: d.inst_num = num_sltiu;
                    3'd4: d.inst_num = num_xori;
                    3'd5: d.inst_num = f7z ? num_srli : (f7a ? num_srai : num_inv);
                    3'd6: d.inst_num = num_ori;
                    default: d.inst_num = num_andi;
                endcase
            end
            7'b0110011: begin
                d.rd  = w[11:7];
                d.rs2 = w[24:20];
                case (f3)
                    3'd0: d.inst_num = f7z ? num_add : (f7a ? num_sub : num_inv);
                    3'd1: d.inst_num = f7z ? num_sll : num_inv;
                    3'd2: d.inst_num = f7z ? num_slt : num_inv;
                    3'd3: d.inst_num = f7z ? num_sltu : num_inv;
                    3'd4: d.inst_num = f7z ? num_xor : num_inv;
                    3'd5: d.inst_num = f7z ? num_srl : (f7a ? num_sra : num_inv);
                    3'd6: d.inst_num = f7z ? num_or : num_inv;
                    default: d.inst_num = f7z ? num_and : num_inv;
                endcase
            end
            7'b1110011: begin
                d.imm      = i_imm;
                d.inst_num = (w == 32'h00100073) ? num_ebreak : num_inv;
            end
            default: d.inst_num = num_inv;
        endcase
        d.rd_we = (d.inst_num != num_inv) && (d.inst_num != num_ebreak) &&
                  (opc != 7'b0100011) && (opc != 7'b1100011);
        return d;
    endfunction

    // picks a class first, then fills and sometimes spoils its fields.
    function automatic logic [31:0] gen_word();
        logic [31:0] r;
        logic [31:0] w;
        r = lcg_next();
        w = lcg_next();
        case (r[27:24])
            4'd0: w[6:0] = 7'b0000011;
            4'd1: w[6:0] = 7'b0100011;
            4'd2: w[6:0] = 7'b1100011;
            4'd3: w[6:0] = 7'b1101111;
            4'd4: begin
                w[6:0] = 7'b1100111;
                if (r[20])
                    w[14:12] = 3'd0;
            end
            4'd5: w[6:0] = 7'b0110111;
            4'd6: w[6:0] = 7'b0010111;
            4'd7, 4'd8: begin
                w[6:0] = 7'b0010011;
                if (r[27:24] == 4'd7 && w[13:12] == 2'b01)
                    w[31:25] = r[30] ? 7'h20 : 7'h00; // legal shift funct7.
            end
            4'd9, 4'd10, 4'd11: begin
                w[6:0] = 7'b0110011;
                if (r[27:24] != 4'd11)
                    w[31:25] = r[30] ? 7'h20 : 7'h00;
            end
            4'd12: w = 32'h00100073;
            4'd13: w = 32'h00100073 ^ (32'd1 << r[4:0]); // one bit off ebreak.
            4'd14: w[1:0] = {r[19], 1'b0}; // not a 32-bit opcode.
            default: w = w;
        endcase
        return w;
    endfunction

    task automatic note_timeout(input string what);
        fail_cnt++;
        timed_out = 1'b1;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    // one clock; transfers are read mid-cycle and booked after the edge.
    task automatic step_cycle(output logic in_fire);
        logic        out_fire;
        logic [31:0] r;
        @(negedge clk);
        in_fire  = in_valid && in_ready;
        out_fire = out_valid && out_ready;
        @(posedge clk);
        #1;
        if (out_fire && exp_q.size() > 0)
            void'(exp_q.pop_front());
        if (in_fire) begin
            last_exp = ref_decode(inst);
            exp_q.push_back(last_exp);
            seen[last_exp.inst_num] = 1'b1;
            sent++;
        end
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
        pending  = exp_q.size();
        if (random_ready) begin
            r = lcg_next();
            out_ready = r[29];
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        logic fired;
        int   waited;
        inst     = w;
        in_valid = 1'b1;
        fired    = 1'b0;
        waited   = 0;
        while (!fired && !timed_out) begin
            step_cycle(fired);
            waited++;
            if (!fired && waited > 50)
                note_timeout("in_ready");
        end
        in_valid = 1'b0;
    endtask

    a_pending: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> pending > 0)
        else begin
            fail_cnt++;
            $display("output transfer at %0t with no word pending", $time);
        end

    a_order: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready && pending > 0 |-> out == exp_head)
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: out expected %h got %h", $time, exp_head, $sampled(out));
        end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && in_ready |=> out_valid && out == last_exp)
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: out one cycle after accept expected %h got %h (valid %b)",
                     $time, last_exp, $sampled(out), $sampled(out_valid));
        end

    a_stall: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else begin
            fail_cnt++;
            $display("output changed or dropped while stalled at %0t", $time);
        end

    a_ready: assert property (@(posedge clk) disable iff (!arst_n)
        in_ready == (!out_valid || out_ready))
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: in_ready expected %b got %b", $time,
                     !$sampled(out_valid) || $sampled(out_ready), $sampled(in_ready));
        end

    initial begin
        int          n;
        int          waited;
        logic        fired;
        logic [31:0] r;
        lcg_state    = 32'h773a;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        inst         = '0;
        random_ready = 1'b0;
        timed_out    = 1'b0;
        sent         = 0;
        pending      = 0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        exp_head     = '0;
        last_exp     = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        assert (!out_valid && in_ready) else begin
            fail_cnt++;
            $display("after reset out_valid is not low or in_ready is not high");
        end

        for (n = 0; n < 300 && !timed_out; n++)
            send_word(gen_word()); // back to back at full rate.

        random_ready = 1'b1;
        for (n = 0; n < 600 && !timed_out; n++) begin
            r = lcg_next();
            if (r[28])
                step_cycle(fired); // idle cycle on the input side.
            send_word(gen_word());
        end

        random_ready = 1'b0;
        out_ready    = 1'b1;
        waited       = 0;
        while (exp_q.size() > 0 && !timed_out) begin
            step_cycle(fired);
            waited++;
            if (exp_q.size() > 0 && waited > 20)
                note_timeout("the output to drain");
        end

        for (n = int'(num_lui); n <= int'(num_ebreak) && !timed_out; n++) begin
            if (!seen[n]) begin
                fail_cnt++;
                $display("instruction number %0d was never produced", n);
            end
        end

        $display("%0d words sent, %0d mismatches, %0d other failures",
                 sent, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/rv_isa_pkg.sv
rtl/idu_pkg.sv
rtl/idu_opcode.sv
rtl/idu_funct3.sv
rtl/idu_funct7.sv
rtl/idu_imm_gen.sv
rtl/idu_ctrl.sv
rtl/idu_top.sv
verification/tb_idu_top.sv
